//--- source/srtc_pkg.sv
package srtc_pkg;

  // Fifteen BCD nibbles with seconds units in the low nibble and weekday on top
  typedef logic [59:0] rtc_time_t;

  // Nibble index of the units digit of each field
  localparam int DIG_SEC     = 0;
  localparam int DIG_MIN     = 2;
  localparam int DIG_HOUR    = 4;
  localparam int DIG_DAY     = 6;
  localparam int DIG_MONTH   = 8;
  localparam int DIG_YEAR    = 10;
  localparam int DIG_CENTURY = 12;
  localparam int DIG_WEEKDAY = 14;

  // Reset time is midnight on day 1 of month 1, year 00 of century 20, weekday 6
  localparam rtc_time_t RTC_EPOCH = 60'h620_0001_0100_0000;

  // Control register command codes
  localparam logic [3:0] CMD_READ    = 4'hd;
  localparam logic [3:0] CMD_COMMAND = 4'he;
  localparam logic [3:0] CMD_NOP     = 4'hf;
  localparam logic [3:0] CMD_SET     = 4'h0;
  localparam logic [3:0] CMD_IDLE    = 4'h4;

  // One-hot host port modes
  typedef enum logic [4:0] {
    SRTC_IDLE       = 5'b00001,
    SRTC_READ       = 5'b00010,
    SRTC_COMMAND    = 5'b00100,
    SRTC_WRITE      = 5'b01000,
    SRTC_WRITE_HOLD = 5'b10000
  } srtc_mode_e;

  // Pointer value where the next data read takes a snapshot
  localparam logic [3:0] PTR_SNAPSHOT = 4'hf;
  localparam logic [3:0] LAST_DIGIT = 4'd12;

  // Write strobe countdown for six cycles of rtc_we
  localparam logic [2:0] WE_HOLD_CYCLES = 3'd5;

endpackage

//--- source/srtc_port.sv
module srtc_port
  import srtc_pkg::*;
(
  input  logic       clkin,
  input  logic       reset_rising,
  input  logic       enable,
  input  logic       addr_in,
  input  logic [7:0] data_in,
  input  logic       reg_we,
  input  logic       reg_oe,
  output logic [7:0] data_out,
  input  rtc_time_t  cur_time,
  output logic       rtc_we,
  output rtc_time_t  rtc_wdata
);

  ////////////////////////////////////////////////////////////
  // Strobe sampling
  ////////////////////////////////////////////////////////////

  logic [5:0] oe_sreg;
  logic [1:0] we_sreg;
  logic       oe_falling;
  logic       we_rising;

  always_ff @(posedge clkin) begin
    if (reset_rising) begin
      oe_sreg <= '0;
      we_sreg <= '0;
    end else begin
      oe_sreg <= {oe_sreg[4:0], reg_oe};
      we_sreg <= {we_sreg[0], reg_we};
    end
  end

  // Five high samples then one low
  assign oe_falling = (oe_sreg == 6'b111110);
  assign we_rising  = (we_sreg == 2'b01);

  ////////////////////////////////////////////////////////////
  // Read digit mux
  ////////////////////////////////////////////////////////////

  srtc_mode_e mode_r;
  logic [3:0] rtc_ptr;
  logic [2:0] we_countdown;
  rtc_time_t  snap_r;
  logic [3:0] wr_nib;
  logic [7:0] rd_digit;
  logic [7:0] snap_month;
  logic [7:0] snap_century;

  assign wr_nib = data_in[3:0];

  // Month and century go out as binary sums of the two BCD digits
  assign snap_month   = {4'h0, snap_r[DIG_MONTH*4+4 +: 4]} * 8'd10
                      + {4'h0, snap_r[DIG_MONTH*4 +: 4]};
  assign snap_century = {4'h0, snap_r[DIG_CENTURY*4+4 +: 4]} * 8'd10
                      + {4'h0, snap_r[DIG_CENTURY*4 +: 4]};

  always_comb begin
    case (rtc_ptr)
      4'd8:       rd_digit = snap_month;
      4'd9:       rd_digit = {4'h0, snap_r[DIG_YEAR*4 +: 4]};
      4'd10:      rd_digit = {4'h0, snap_r[DIG_YEAR*4+4 +: 4]};
      4'd11:      rd_digit = snap_century - 8'd10;
      LAST_DIGIT: rd_digit = {4'h0, snap_r[DIG_WEEKDAY*4 +: 4]};
      default: begin
        // Pointers 0 to 7 map straight onto the low nibbles
        if (rtc_ptr < 4'd8) begin
          rd_digit = {4'h0, snap_r[4*rtc_ptr[2:0] +: 4]};
        end else begin
          rd_digit = 8'h0f;
        end
      end
    endcase
  end

  ////////////////////////////////////////////////////////////
  // Command FSM
  ////////////////////////////////////////////////////////////

  always_ff @(posedge clkin) begin
    if (reset_rising) begin
      mode_r       <= SRTC_READ;
      rtc_ptr      <= PTR_SNAPSHOT;
      rtc_we       <= 1'b0;
      we_countdown <= '0;
      data_out     <= 8'h00;
    end else if (mode_r == SRTC_WRITE_HOLD) begin
      // Bus is ignored while the store takes the write
      we_countdown <= we_countdown - 3'd1;
      if (we_countdown == 3'd0) begin
        mode_r <= SRTC_WRITE;
        rtc_we <= 1'b0;
      end
    end else if (we_rising && enable) begin
      // Data register is read only, so only control writes count
      if (addr_in) begin
        case (wr_nib)
          CMD_READ: begin
            mode_r  <= SRTC_READ;
            rtc_ptr <= PTR_SNAPSHOT;
          end
          CMD_COMMAND: begin
            mode_r <= SRTC_COMMAND;
          end
          CMD_NOP: begin
          end
          default: begin
            if (mode_r == SRTC_COMMAND) begin
              if (wr_nib == CMD_SET) begin
                mode_r    <= SRTC_WRITE;
                rtc_wdata <= cur_time;
                rtc_ptr   <= 4'd0;
              end else if (wr_nib == CMD_IDLE) begin
                mode_r  <= SRTC_IDLE;
                rtc_ptr <= PTR_SNAPSHOT;
              end else begin
                mode_r <= SRTC_IDLE;
              end
            end else if (mode_r == SRTC_WRITE) begin
              rtc_ptr <= rtc_ptr + 4'd1;
              case (rtc_ptr)
                4'd8: begin
                  // Month 10 to 12 sets the tens digit
                  rtc_wdata[DIG_MONTH*4 +: 4]   <= (wr_nib < 4'd10) ? wr_nib
                                                                    : wr_nib - 4'd10;
                  rtc_wdata[DIG_MONTH*4+4 +: 4] <= (wr_nib < 4'd10) ? 4'd0 : 4'd1;
                end
                4'd9:  rtc_wdata[DIG_YEAR*4 +: 4]   <= wr_nib;
                4'd10: rtc_wdata[DIG_YEAR*4+4 +: 4] <= wr_nib;
                4'd11: begin
                  // Century offset by ten, 9 is 19xx
                  rtc_wdata[DIG_CENTURY*4 +: 4]   <= (wr_nib < 4'd10) ? wr_nib
                                                                      : wr_nib - 4'd10;
                  rtc_wdata[DIG_CENTURY*4+4 +: 4] <= (wr_nib < 4'd10) ? 4'd1 : 4'd2;
                end
                default: begin
                  if (rtc_ptr < 4'd8) begin
                    rtc_wdata[4*rtc_ptr[2:0] +: 4] <= wr_nib;
                  end
                end
              endcase
              mode_r       <= SRTC_WRITE_HOLD;
              we_countdown <= WE_HOLD_CYCLES;
              rtc_we       <= 1'b1;
            end
          end
        endcase
      end
    end else if (oe_falling && enable && !addr_in) begin
      if (mode_r == SRTC_READ) begin
        if (rtc_ptr == PTR_SNAPSHOT) begin
          snap_r <= cur_time;
        end
        data_out <= rd_digit;
        // One 0x0f trailer after the weekday, then back to snapshot
        rtc_ptr  <= (rtc_ptr == LAST_DIGIT + 4'd1) ? PTR_SNAPSHOT : rtc_ptr + 4'd1;
      end else begin
        data_out <= 8'h00;
      end
    end
  end

endmodule

//--- source/rtc_tick.sv
module rtc_tick
  import srtc_pkg::*;
#(
  parameter int TICKS_PER_SECOND = 8
) (
  input  logic      clkin,
  input  logic      reset_rising,
  input  rtc_time_t cur_time,
  output logic      tick,
  output rtc_time_t next_time
);

  localparam int CNT_W = (TICKS_PER_SECOND > 1) ? $clog2(TICKS_PER_SECOND) : 1;

  ////////////////////////////////////////////////////////////
  // Seconds prescaler
  ////////////////////////////////////////////////////////////

  logic [CNT_W-1:0] presc_r;

  always_ff @(posedge clkin) begin
    if (reset_rising || tick) begin
      presc_r <= '0;
    end else begin
      presc_r <= presc_r + 1'b1;
    end
  end

  assign tick = (presc_r == CNT_W'(TICKS_PER_SECOND - 1));

  ////////////////////////////////////////////////////////////
  // Calendar advance
  ////////////////////////////////////////////////////////////

  function automatic logic [7:0] bcd_inc(input logic [7:0] v);
    bcd_inc = (v[3:0] == 4'd9) ? {v[7:4] + 4'd1, 4'd0} : {v[7:4], v[3:0] + 4'd1};
  endfunction

  logic [7:0] sec_v, min_v, hour_v, day_v, month_v, year_v, cent_v;
  logic [3:0] wday_v;
  logic [7:0] month_bin, year_bin, last_day;
  logic       leap;
  logic       c_min, c_hour, c_day, c_month, c_year, c_cent;

  assign sec_v   = cur_time[DIG_SEC*4 +: 8];
  assign min_v   = cur_time[DIG_MIN*4 +: 8];
  assign hour_v  = cur_time[DIG_HOUR*4 +: 8];
  assign day_v   = cur_time[DIG_DAY*4 +: 8];
  assign month_v = cur_time[DIG_MONTH*4 +: 8];
  assign year_v  = cur_time[DIG_YEAR*4 +: 8];
  assign cent_v  = cur_time[DIG_CENTURY*4 +: 8];
  assign wday_v  = cur_time[DIG_WEEKDAY*4 +: 4];

  assign month_bin = {4'h0, month_v[7:4]} * 8'd10 + {4'h0, month_v[3:0]};
  assign year_bin  = {4'h0, year_v[7:4]} * 8'd10 + {4'h0, year_v[3:0]};
  // Two-digit year rule only
  assign leap      = (year_bin[1:0] == 2'b00);

  // Last day of the month in BCD
  always_comb begin
    case (month_bin)
      8'd2:                      last_day = leap ? 8'h29 : 8'h28;
      8'd4, 8'd6, 8'd9, 8'd11:   last_day = 8'h30;
      default:                   last_day = 8'h31;
    endcase
  end

  assign c_min   = (sec_v == 8'h59);
  assign c_hour  = c_min && (min_v == 8'h59);
  assign c_day   = c_hour && (hour_v == 8'h23);
  assign c_month = c_day && (day_v == last_day);
  assign c_year  = c_month && (month_v == 8'h12);
  assign c_cent  = c_year && (year_v == 8'h99);

  always_comb begin
    next_time = cur_time;
    next_time[DIG_SEC*4 +: 8] = c_min ? 8'h00 : bcd_inc(sec_v);
    if (c_min) begin
      next_time[DIG_MIN*4 +: 8] = c_hour ? 8'h00 : bcd_inc(min_v);
    end
    if (c_hour) begin
      next_time[DIG_HOUR*4 +: 8] = c_day ? 8'h00 : bcd_inc(hour_v);
    end
    if (c_day) begin
      next_time[DIG_DAY*4 +: 8]     = c_month ? 8'h01 : bcd_inc(day_v);
      next_time[DIG_WEEKDAY*4 +: 4] = (wday_v >= 4'd6) ? 4'd0 : wday_v + 4'd1;
    end
    if (c_month) begin
      next_time[DIG_MONTH*4 +: 8] = c_year ? 8'h01 : bcd_inc(month_v);
    end
    if (c_year) begin
      next_time[DIG_YEAR*4 +: 8] = c_cent ? 8'h00 : bcd_inc(year_v);
    end
    if (c_cent) begin
      next_time[DIG_CENTURY*4 +: 8] = (cent_v == 8'h99) ? 8'h00 : bcd_inc(cent_v);
    end
  end

endmodule

//--- source/rtc_store.sv
module rtc_store
  import srtc_pkg::*;
(
  input  logic      clkin,
  input  logic      reset_rising,
  input  logic      rtc_we,
  input  rtc_time_t rtc_wdata,
  input  logic      tick,
  input  rtc_time_t next_time,
  output rtc_time_t cur_time
);

  // Host write wins, a tick in the same cycle is dropped
  always_ff @(posedge clkin) begin
    if (reset_rising) begin
      cur_time <= RTC_EPOCH;
    end else if (rtc_we) begin
      cur_time <= rtc_wdata;
    end else if (tick) begin
      cur_time <= next_time;
    end
  end

endmodule

//--- source/srtc_top.sv
module srtc_top
  import srtc_pkg::*;
#(
  parameter int TICKS_PER_SECOND = 21_477_272
) (
  input  logic       clkin,
  input  logic       reset_rising,
  input  logic       enable,
  input  logic       addr_in,
  input  logic [7:0] data_in,
  input  logic       reg_we,
  input  logic       reg_oe,
  output logic [7:0] data_out
);

  logic      rtc_we;
  rtc_time_t rtc_wdata;
  rtc_time_t cur_time;
  logic      tick;
  rtc_time_t next_time;

  // Host register port
  srtc_port i_port (
    .clkin        (clkin),
    .reset_rising (reset_rising),
    .enable       (enable),
    .addr_in      (addr_in),
    .data_in      (data_in),
    .reg_we       (reg_we),
    .reg_oe       (reg_oe),
    .data_out     (data_out),
    .cur_time     (cur_time),
    .rtc_we       (rtc_we),
    .rtc_wdata    (rtc_wdata)
  );

  rtc_tick #(
    .TICKS_PER_SECOND (TICKS_PER_SECOND)
  ) i_tick (
    .clkin        (clkin),
    .reset_rising (reset_rising),
    .cur_time     (cur_time),
    .tick         (tick),
    .next_time    (next_time)
  );

  rtc_store i_store (
    .clkin        (clkin),
    .reset_rising (reset_rising),
    .rtc_we       (rtc_we),
    .rtc_wdata    (rtc_wdata),
    .tick         (tick),
    .next_time    (next_time),
    .cur_time     (cur_time)
  );

endmodule

//--- tb/srtc_tb_asserts.sv
module srtc_store_asserts
  import srtc_pkg::*;
(
  input logic      clkin,
  input logic      reset_rising,
  input logic      rtc_we,
  input rtc_time_t rtc_wdata,
  input logic      tick,
  input rtc_time_t next_time,
  input rtc_time_t cur_time
);
  timeunit 1ns;
  timeprecision 1ps;

  // Number of failed assertions
  int fail_count = 0;

  // Host write lands on the next edge
  a_write_load: assert property (@(posedge clkin) disable iff (reset_rising)
    rtc_we |=> cur_time == $past(rtc_wdata))
  else begin
    fail_count++;
    $error("write not loaded");
  end

  a_tick_load: assert property (@(posedge clkin) disable iff (reset_rising)
    tick && !rtc_we |=> cur_time == $past(next_time))
  else begin
    fail_count++;
    $error("tick not loaded");
  end

  a_tick_pulse: assert property (@(posedge clkin) disable iff (reset_rising)
    tick |=> !tick)
  else begin
    fail_count++;
    $error("tick longer than one cycle");
  end

endmodule

bind rtc_store srtc_store_asserts i_store_asserts (.*);

//--- tb/srtc_tb.sv
module srtc_tb
  import srtc_pkg::*;
;
  timeunit 1ns;
  timeprecision 1ps;

  localparam int TPS = 8;
  localparam int NUM_OPS = 160;
  localparam int WAIT_SECS = 6;

  logic clkin, reset_rising, enable, addr_in, reg_we, reg_oe;
  logic [7:0] data_in, data_out;
  int cyc = 0;
  int rst_end, ref_cyc;
  rtc_time_t ref_time, snap;
  logic [31:0] lfsr_state = 32'h0061d459;
  logic [7:0] exp_q[$];
  logic [7:0] act_q[$];
  int wr_digits[13];

  srtc_top #(.TICKS_PER_SECOND(TPS)) i_dut (.*);

  initial begin
    clkin = 1'b0;
    forever #50 clkin = ~clkin;
  end

  always @(posedge clkin) cyc <= cyc + 1;

  task automatic check_equal(input logic [7:0] expected, input logic [7:0] actual,
                             input string what);
    if (expected !== actual) begin
      $display("Fail at %0t ns: %s expected %h got %h", $time, what, expected, actual);
      $display("Simulation finished: FAIL");
      $fatal(1);
    end
  endtask

  // Compare process pairs expected and sampled read data
  always @(posedge clkin) begin
    while (exp_q.size() > 0 && act_q.size() > 0) begin
      check_equal(exp_q.pop_front(), act_q.pop_front(), "data_out");
    end
  end

  // Bound store checker
  always @(i_dut.i_store.i_store_asserts.fail_count) begin
    if (i_dut.i_store.i_store_asserts.fail_count != 0) begin
      $display("Error at %0t ns: an assertion on the time store failed", $time);
      $display("Simulation finished: FAIL");
      $fatal(1);
    end
  end

  initial begin
    #((NUM_OPS * 20 + WAIT_SECS * TPS + 500) * 100);
    $display("Timeout: the DUT did not finish the tests in time");
    $display("Simulation finished: FAIL");
    $fatal(1);
  end

  ////////////////////////////////////////////////////////////
  // Reference model
  ////////////////////////////////////////////////////////////

  function automatic int days_in(int m, int y);
    if (m == 2) return (y % 4 == 0) ? 29 : 28;
    if (m == 4 || m == 6 || m == 9 || m == 11) return 30;
    return 31;
  endfunction

  // Field order sec, min, hour, day, month, year, century
  function automatic rtc_time_t advance(rtc_time_t t, int n);
    int f[7];
    int wd;
    for (int i = 0; i < 7; i++) f[i] = t[8*i+4 +: 4] * 10 + t[8*i +: 4];
    wd = t[59:56];
    repeat (n) begin
      f[0]++;
      if (f[0] == 60) begin
        f[0] = 0;
        f[1]++;
      end
      if (f[1] == 60) begin
        f[1] = 0;
        f[2]++;
      end
      if (f[2] == 24) begin
        f[2] = 0;
        f[3]++;
        wd = (wd + 1) % 7;
      end
      if (f[3] > days_in(f[4], f[5])) begin
        f[3] = 1;
        f[4]++;
      end
      if (f[4] == 13) begin
        f[4] = 1;
        f[5]++;
      end
      if (f[5] == 100) begin
        f[5] = 0;
        f[6] = (f[6] + 1) % 100;
      end
    end
    for (int i = 0; i < 7; i++) begin
      t[8*i +: 4]   = 4'(f[i] % 10);
      t[8*i+4 +: 4] = 4'(f[i] / 10);
    end
    t[59:56] = 4'(wd);
    return t;
  endfunction

  function automatic rtc_time_t put_digit(rtc_time_t t, int p, int v);
    if (p < 8) t[4*p +: 4] = 4'(v);
    else if (p == 8) t[39:32] = {4'(v / 10), 4'(v % 10)};
    else if (p == 9) t[43:40] = 4'(v);
    else if (p == 10) t[47:44] = 4'(v);
    else if (p == 11) t[55:48] = {(v < 10) ? 4'd1 : 4'd2, 4'(v % 10)};
    return t;
  endfunction

  function automatic logic [7:0] read_digit(rtc_time_t t, int p);
    if (p < 8) return t[4*p +: 4];
    if (p == 8) return 8'(t[39:36] * 10 + t[35:32]);
    if (p == 9) return t[43:40];
    if (p == 10) return t[47:44];
    if (p == 11) return 8'(t[55:52] * 10 + t[51:48] - 10);
    return t[59:56];
  endfunction

  // Ticks fall on edges TPS apart counting from the end of reset
  function automatic int count_ticks(int first, int last);
    int n = 0;
    for (int e = first; e <= last; e++) begin
      if (e >= rst_end && (e - rst_end) % TPS == TPS - 1) n++;
    end
    return n;
  endfunction

  // Galois LFSR with one step per bit taken
  function automatic int rand_below(int n);
    logic [7:0] bits;
    for (int i = 0; i < 8; i++) begin
      bits[i] = lfsr_state[0];
      lfsr_state = lfsr_state[0] ? (lfsr_state >> 1) ^ 32'ha3000000 : lfsr_state >> 1;
    end
    return bits % n;
  endfunction

  ////////////////////////////////////////////////////////////
  // Bus tasks
  ////////////////////////////////////////////////////////////

  task automatic write_ctrl(input int nib, output int c0);
    @(posedge clkin);
    #10;
    c0 = cyc;
    addr_in = 1'b1;
    data_in = 8'(nib);
    reg_we = 1'b1;
    repeat (3) @(posedge clkin);
    #10 reg_we = 1'b0;
    repeat (10) @(posedge clkin);
  endtask

  task automatic read_data(output int c_r);
    @(posedge clkin);
    #10;
    c_r = cyc;
    addr_in = 1'b0;
    reg_oe = 1'b1;
    repeat (8) @(posedge clkin);
    #10 reg_oe = 1'b0;
    repeat (4) @(posedge clkin);
    #10 act_q.push_back(data_out);
  endtask

  // Snapshot holds the time after edge c_r+9
  task automatic read_sequence(output rtc_time_t s);
    int c;
    read_data(c);
    s = advance(ref_time, count_ticks(ref_cyc + 1, c + 9));
    exp_q.push_back(8'h0f);
    for (int p = 0; p <= LAST_DIGIT; p++) begin
      read_data(c);
      exp_q.push_back(read_digit(s, p));
    end
    read_data(c);
    exp_q.push_back(8'h0f);
  endtask

  task automatic set_time();
    int c;
    rtc_time_t w;
    write_ctrl(CMD_COMMAND, c);
    write_ctrl(CMD_SET, c);
    w = advance(ref_time, count_ticks(ref_cyc + 1, c + 1));
    for (int p = 0; p <= LAST_DIGIT; p++) begin
      write_ctrl(wr_digits[p], c);
      w = put_digit(w, p, wr_digits[p]);
    end
    ref_time = w;
    ref_cyc = c + 8;
  endtask

  task automatic load_digits(int s, int mi, int h, int d, int mo, int y, int ce);
    wr_digits = '{s % 10, s / 10, mi % 10, mi / 10, h % 10, h / 10, d % 10, d / 10,
                  mo, y % 10, y / 10, ce, 0};
  endtask

  initial begin
    int c, v[7];
    reset_rising = 1'b1;
    {enable, addr_in, reg_we, reg_oe} = 4'b1000;
    data_in = 8'h00;
    repeat (3) @(posedge clkin);
    #10 reset_rising = 1'b0;
    rst_end = cyc + 1;
    ref_time = RTC_EPOCH;
    ref_cyc = rst_end - 1;

    // Epoch readback
    read_sequence(snap);

    // Random legal time with century code 9 or 10
    v[0] = rand_below(60);
    v[1] = rand_below(60);
    v[2] = rand_below(24);
    v[3] = rand_below(28);
    v[4] = rand_below(12);
    v[5] = rand_below(100);
    v[6] = rand_below(2);
    load_digits(v[0], v[1], v[2], v[3] + 1, v[4] + 1, v[5], v[6] + 9);
    set_time();
    write_ctrl(CMD_READ, c);
    read_sequence(snap);

    // Leap and common February rollover
    for (int y = 4; y <= 5; y++) begin
      load_digits(58, 59, 23, 28, 2, y, 10);
      set_time();
      repeat (3 * TPS) @(posedge clkin);
      write_ctrl(CMD_READ, c);
      read_sequence(snap);
      check_equal((y == 4) ? 8'h29 : 8'h01, snap[31:24], "rollover day");
      check_equal((y == 4) ? 8'h02 : 8'h03, snap[39:32], "rollover month");
    end

    // Idle mode
    write_ctrl(CMD_COMMAND, c);
    write_ctrl(CMD_IDLE, c);
    read_data(c);
    exp_q.push_back(8'h00);
    write_ctrl(3, c);
    write_ctrl(7, c);
    write_ctrl(CMD_READ, c);
    read_sequence(snap);

    // Bus ignored while disabled
    enable = 1'b0;
    write_ctrl(CMD_COMMAND, c);
    write_ctrl(CMD_SET, c);
    write_ctrl(5, c);
    read_data(c);
    exp_q.push_back(8'h0f);
    enable = 1'b1;
    read_sequence(snap);

    repeat (2) @(posedge clkin);
    check_equal(8'd0, 8'(exp_q.size() + act_q.size()), "unmatched reads");
    $display("Simulation finished: PASS");
    $finish;
  end

endmodule

//--- Bender.yml
package:
  name: srtc

sources:
  - source/srtc_pkg.sv
  - source/srtc_port.sv
  - source/rtc_tick.sv
  - source/rtc_store.sv
  - source/srtc_top.sv
  - target: test
    files:
      - tb/srtc_tb_asserts.sv
      - tb/srtc_tb.sv

//--- srtc_top.f
source/srtc_pkg.sv
source/srtc_port.sv
source/rtc_tick.sv
source/rtc_store.sv
source/srtc_top.sv
tb/srtc_tb_asserts.sv
tb/srtc_tb.sv
